// File: files.f
verilog/apu_pkg.sv
verilog/apu_code_ram.sv
verilog/apu_alu.sv
verilog/apu_core.sv
verilog/apu_port_out.sv
verilog/apu.sv
tb/apu_checker.sv
tb/apu_tb.sv

// File: Bender.yml
package:
  name: apu

sources:
  - verilog/apu_pkg.sv
  - verilog/apu_code_ram.sv
  - verilog/apu_alu.sv
  - verilog/apu_core.sv
  - verilog/apu_port_out.sv
  - verilog/apu.sv
  - target: test
    files:
      - tb/apu_checker.sv
      - tb/apu_tb.sv

// File: tb/apu_tb.sv
`timescale 1ns/1ps

module apu_tb;

	import apu_pkg::*;

	typedef logic [8:0] wr_t; // {covox, data} with border data zero extended
	typedef wr_t wr_list_t[$];

	localparam int NUM_TESTS = 6;
	localparam int TEST_CYCLES = 3000;
	localparam int RUN_LIMIT = 2500; // cycles or model steps to reach halt

	bit                  clk;
	logic                rst;
	logic                apu_halt;
	logic                code_wen;
	logic [8:0]          code_waddr;
	logic [7:0]          code_wdata;
	logic                apu_rdy;
	logic [BORDER_W-1:0] apu_border;
	logic                apu_border_we;
	logic [7:0]          apu_covox;
	logic                apu_covox_we;

	opcode_t    prog [CODE_DEPTH]; // program under construction
	int         prog_len;
	logic [7:0] mregs [NUM_GPR];  // model registers kept across runs
	flags_t     mflags;
	wr_list_t   exp_q;
	wr_list_t   obs_q;
	int         errors;
	int         checks;
	int         err_mark;
	integer     seed;
	logic       compare_req;
	logic       compare_ack;

	apu dut0
	(
		.clk           (clk),
		.rst           (rst),
		.apu_halt      (apu_halt),
		.code_wen      (code_wen),
		.code_waddr    (code_waddr),
		.code_wdata    (code_wdata),
		.apu_rdy       (apu_rdy),
		.apu_border    (apu_border),
		.apu_border_we (apu_border_we),
		.apu_covox     (apu_covox),
		.apu_covox_we  (apu_covox_we)
	);

	always #50 clk = ~clk; // 100 ns period

	function automatic opcode_t insn(op_group_e grp, logic [3:0] hi, logic [7:0] lo);
		return {grp, hi, lo};
	endfunction

	function automatic logic [7:0] rand_byte();
		return 8'($random(seed));
	endfunction

	function automatic string port_name(logic covox);
		return covox ? "apu_covox" : "apu_border";
	endfunction

	function automatic logic jump_taken(logic [3:0] cond, flags_t f);
		case (jcond_e'(cond))
			jc_always: return 1'b1;
			jc_z:      return f.z;
			jc_c:      return f.c;
			jc_nz:     return !f.z;
			jc_gt:     return !f.c && !f.z;
			jc_le:     return f.c || f.z;
			jc_nc:     return !f.c;
			jc_n:      return f.n;
			jc_p:      return !f.n;
			default:   return 1'b0; // unused codes never jump
		endcase
	endfunction

	// ISA interpreter returning the port writes up to the halt word
	function automatic wr_list_t run_model(int len);
		wr_list_t   q;
		int         pc;
		int         steps;
		opcode_t    w;
		logic [3:0] d;
		logic [3:0] s;
		logic [7:0] im;
		logic [8:0] r; // result with carry or borrow on top
		pc = 0;
		for (steps = 0; steps < RUN_LIMIT; steps++)
		begin
			if (pc >= len)
			begin
				$display("model ran past the end of the program at word %0d", pc);
				errors++;
				return q;
			end
			w = prog[pc];
			if (w == HALT_WORD)
				return q;
			d = w[11:8];
			s = w[3:0];
			im = w[7:0];
			pc = (pc + 1) % CODE_DEPTH;
			case (op_group_e'(w[15:12]))
				op_ld:          mregs[d] = im;
				op_mov:         mregs[d] = mregs[s];
				op_and, op_tst: r = {1'b0, mregs[d] & im};
				op_or:          r = {1'b0, mregs[d] | im};
				op_xor:         r = {1'b0, mregs[d] ^ im};
				op_add:         r = {1'b0, mregs[d]} + {1'b0, im};
				op_sub, op_cmp: r = {mregs[d] < im, mregs[d] - im};
				op_jr:
				begin
					// signed offset relative to the next word
					if (jump_taken(w[11:8], mflags))
						pc = (pc + (im[7] ? int'(im) - 256 : int'(im)) + CODE_DEPTH) % CODE_DEPTH;
				end
				op_out:
				begin
					if (s == port_border)
						q.push_back({1'b0, {(8 - BORDER_W){1'b0}}, mregs[d][BORDER_W-1:0]});
					else if (s == port_covox)
						q.push_back({1'b1, mregs[d]});
				end
				default:
				begin
				end
			endcase
			if (w[15:12] inside {[4'd1:4'd7]}) // flag setting groups
			begin
				mflags.z = (r[7:0] == 8'd0);
				mflags.c = r[8];
				mflags.n = r[7];
				if (!(w[15:12] inside {op_tst, op_cmp}))
					mregs[d] = r[7:0];
			end
		end
		$display("model found no halt word within %0d steps", RUN_LIMIT);
		errors++;
		return q;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic put(opcode_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// low byte to the even address and high byte to the odd one
	task automatic load_program();
		int i;
		next_cycle();
		for (i = 0; i < prog_len; i++)
		begin
			code_wen = 1'b1;
			code_waddr = {i[7:0], 1'b0};
			code_wdata = prog[i][7:0];
			next_cycle();
			code_waddr = {i[7:0], 1'b1};
			code_wdata = prog[i][15:8];
			next_cycle();
		end
		code_wen = 1'b0;
	endtask

	task automatic run_program();
		int n;
		exp_q = run_model(prog_len);
		obs_q.delete();
		repeat (2) next_cycle(); // halt held while word 0 is fetched
		apu_halt = 1'b0;
		n = 0;
		// rdy first still shows the forced halt
		@(negedge clk);
		while (apu_rdy !== 1'b0 && n < RUN_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		while (apu_rdy !== 1'b1 && n < RUN_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		checks++;
		if (n >= RUN_LIMIT)
		begin
			$display("%t: program did not reach its halt word in %0d cycles", $time, RUN_LIMIT);
			errors++;
		end
		repeat (4) // parked on halt word
		begin
			@(negedge clk);
			checks++;
			if (apu_rdy !== 1'b1)
			begin
				$display("[ERROR] %t apu_rdy: expected 1 got %b", $time, apu_rdy);
				errors++;
			end
		end
		next_cycle();
		compare_req = 1'b1;
		wait (compare_ack === 1'b1);
		compare_req = 1'b0;
		wait (compare_ack === 1'b0);
		apu_halt = 1'b1;
	endtask

	task automatic end_test(int num, string name);
		$display("test %0d %s: %0d errors", num, name, errors - err_mark);
		err_mark = errors;
	endtask

	// strobe monitor samples mid cycle
	always @(negedge clk)
	begin
		if (apu_border_we === 1'b1)
			obs_q.push_back({1'b0, {(8 - BORDER_W){1'b0}}, apu_border});
		if (apu_covox_we === 1'b1)
			obs_q.push_back({1'b1, apu_covox});
		if ((rst || apu_halt) && (apu_border_we !== 1'b0 || apu_covox_we !== 1'b0))
		begin
			$display("%t: port strobe seen during reset or halt", $time);
			errors++;
		end
	end

	// observed writes against the model
	always
	begin
		int i;
		wait (compare_req === 1'b1);
		checks++;
		if (obs_q.size() != exp_q.size())
		begin
			$display("%t: model expects %0d port writes but the DUT made %0d",
				$time, exp_q.size(), obs_q.size());
			errors++;
		end
		for (i = 0; i < exp_q.size() && i < obs_q.size(); i++)
		begin
			checks++;
			if (obs_q[i][8] != exp_q[i][8])
			begin
				$display("[ERROR] %t write %0d strobe: expected %s got %s", $time, i,
					{port_name(exp_q[i][8]), "_we"}, {port_name(obs_q[i][8]), "_we"});
				errors++;
			end
			else if (obs_q[i][7:0] != exp_q[i][7:0])
			begin
				$display("[ERROR] %t write %0d %s: expected %h got %h", $time, i,
					port_name(exp_q[i][8]), exp_q[i][7:0], obs_q[i][7:0]);
				errors++;
			end
		end
		compare_ack = 1'b1;
		wait (compare_req === 1'b0);
		compare_ack = 1'b0;
	end

	// watchdog
	initial
	begin
		#(NUM_TESTS * TEST_CYCLES * 100);
		$display("timeout: tests still running after %0d cycles", NUM_TESTS * TEST_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		int         k;
		logic [7:0] v;
		$timeformat(-9, 0, " ns", 0);
		seed = 32'h9c0a;
		errors = 0;
		checks = 0;
		err_mark = 0;
		compare_req = 1'b0;
		compare_ack = 1'b0;
		rst = 1'b1;
		apu_halt = 1'b1; // held until the first program is in
		code_wen = 1'b0;
		code_waddr = '0;
		code_wdata = '0;
		mflags = '0; // cleared by reset like the DUT flags
		repeat (4) @(posedge clk);
		#1;
		// still in reset, rdy and port data cleared
		checks++;
		if (apu_rdy !== 1'b0)
		begin
			$display("[ERROR] %t apu_rdy: expected 0 got %b", $time, apu_rdy);
			errors++;
		end
		checks++;
		if (apu_border !== '0)
		begin
			$display("[ERROR] %t apu_border: expected %h got %h", $time,
				{BORDER_W{1'b0}}, apu_border);
			errors++;
		end
		checks++;
		if (apu_covox !== 8'h00)
		begin
			$display("[ERROR] %t apu_covox: expected 00 got %h", $time, apu_covox);
			errors++;
		end
		rst = 1'b0;

		repeat (3) next_cycle();
		@(negedge clk);
		checks++;
		if (apu_rdy !== 1'b1)
		begin
			$display("[ERROR] %t apu_rdy: expected 1 got %b", $time, apu_rdy);
			errors++;
		end
		end_test(1, "reset and halt");

		prog_len = 0;
		for (k = 0; k < 24; k++) // groups 0..7 with each result to covox
		begin
			put(insn(op_group_e'(k % 8), 4'd0, rand_byte()));
			put(insn(op_out, 4'd0, port_covox));
		end
		put(HALT_WORD);
		load_program();
		run_program();
		end_test(2, "immediate alu ops");

		prog_len = 0;
		for (k = 0; k < 32; k++) // cmp then tst over all 16 conditions
		begin
			v = rand_byte();
			put(insn(op_ld, 4'd3, v));
			// every third block forces zero
			put(insn(k < 16 ? op_cmp : op_tst, 4'd3,
				(k % 3 == 0) ? (k < 16 ? v : 8'd0) : rand_byte()));
			put(insn(op_jr, 4'(k % 16), 8'd2)); // taken skips the a0 write
			put(insn(op_ld, 4'd2, 8'ha0 + 8'(k)));
			put(insn(op_out, 4'd2, port_covox));
			put(insn(op_ld, 4'd2, 8'h50 + 8'(k)));
			put(insn(op_out, 4'd2, port_covox));
		end
		put(insn(op_ld, 4'd4, 8'd5)); // countdown 5..1
		put(insn(op_out, 4'd4, port_covox));
		put(insn(op_sub, 4'd4, 8'd1));
		put(insn(op_jr, jc_nz, 8'hfd)); // back to the out
		put(HALT_WORD);
		load_program();
		run_program();
		end_test(3, "flags and jumps");

		prog_len = 0;
		put(insn(op_ld, 4'd5, rand_byte()));
		put(insn(op_mov, 4'd6, 8'd5));
		put(insn(op_out, 4'd6, port_covox));
		put(insn(op_out, 4'd6, port_border));
		put(insn(op_ld, 4'd7, 8'hff));
		put(insn(op_out, 4'd7, port_border)); // only low bits arrive
		put(insn(op_out, 4'd7, 8'd5));        // unused port numbers
		put(insn(op_out, 4'd7, 8'd15));
		put(insn(op_cmp, 4'd7, 8'hff));       // z set
		put(insn(op_mov, 4'd8, 8'd5));        // mov and ld keep z
		put(insn(op_ld, 4'd9, rand_byte()));
		put(insn(op_jr, jc_z, 8'd1));
		put(insn(op_out, 4'd9, port_covox));
		put(insn(op_out, 4'd8, port_border));
		put(HALT_WORD);
		load_program();
		run_program();
		end_test(4, "register move and border width");

		prog_len = 0;
		put(insn(op_add, 4'd0, 8'h11)); // r0 left over from test 2
		put(insn(op_out, 4'd0, port_covox));
		put(16'hb123); // nop group
		put(16'hf000); // misc group but not halt
		put(insn(op_mov, 4'd1, 8'd0));
		put(insn(op_xor, 4'd1, rand_byte()));
		put(insn(op_out, 4'd1, port_border));
		put(HALT_WORD);
		load_program();
		run_program();
		run_program(); // halt pulse restarts at 0 with registers kept
		run_program();
		end_test(5, "halt and restart");

		prog_len = 0;
		put(insn(op_ld, 4'd13, rand_byte()));
		put(insn(op_sub, 4'd13, rand_byte()));
		put(insn(op_jr, jc_c, 8'd1)); // borrow skips one write
		put(insn(op_out, 4'd13, port_covox));
		put(insn(op_add, 4'd13, rand_byte()));
		put(insn(op_out, 4'd13, port_border));
		put(insn(op_out, 4'd0, port_covox));
		put(HALT_WORD);
		load_program();
		run_program();
		end_test(6, "reload");

		checks++;
		if (dut0.port_out0.checker0.fails != 0)
		begin
			$display("%0d assertion failures in the port checker", dut0.port_out0.checker0.fails);
			errors += dut0.port_out0.checker0.fails;
		end
		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: tb/apu_checker.sv
`timescale 1ns/1ps

module apu_checker
(
	input logic              clk,
	input logic              rst,
	input apu_pkg::out_req_t out_req,
	input logic              apu_border_we,
	input logic              apu_covox_we
);

	int fails; // failed assertion count

	// one port per request means never both strobes
	strobe_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(apu_border_we && apu_covox_we))
	else
	begin
		$error("border and covox strobes high in the same cycle");
		fails++;
	end

	// every strobe traces back to a valid request one cycle earlier
	strobe_from_req: assert property (@(posedge clk) disable iff (rst)
		(apu_border_we || apu_covox_we) |-> $past(out_req.valid))
	else
	begin
		$error("port strobe without a request in the previous cycle");
		fails++;
	end

	strobe_quiet_after_rst: assert property (@(posedge clk)
		$past(rst) |-> !apu_border_we && !apu_covox_we)
	else
	begin
		$error("port strobe in the cycle after reset");
		fails++;
	end

endmodule

bind apu_port_out apu_checker checker0
(
	.clk           (clk),
	.rst           (rst),
	.out_req       (out_req),
	.apu_border_we (apu_border_we),
	.apu_covox_we  (apu_covox_we)
);

// File: verilog/apu.sv
`timescale 1ns/1ps

module apu
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          apu_halt,
	input  logic                          code_wen,
	input  logic [8:0]                    code_waddr,
	input  logic [7:0]                    code_wdata,
	output logic                          apu_rdy,
	output logic [apu_pkg::BORDER_W-1:0]  apu_border,
	output logic                          apu_border_we,
	output logic [7:0]                    apu_covox,
	output logic                          apu_covox_we
);

	import apu_pkg::*;

	code_addr_t pc_next;  // core to code memory
	opcode_t    opcode_r; // fetched word
	out_req_t   out_req;  // core to ports

	// host loads code here
	apu_code_ram code_ram0
	(
		.clk        (clk),
		.code_wen   (code_wen),
		.code_waddr (code_waddr),
		.code_wdata (code_wdata),
		.rd_addr    (pc_next),
		.rd_data    (opcode_r)
	);

	apu_core core0
	(
		.clk      (clk),
		.rst      (rst),
		.apu_halt (apu_halt),
		.opcode_r (opcode_r),
		.pc_next  (pc_next),
		.out_req  (out_req),
		.apu_rdy  (apu_rdy)
	);

	// border and covox outputs
	apu_port_out port_out0
	(
		.clk           (clk),
		.rst           (rst),
		.out_req       (out_req),
		.apu_border    (apu_border),
		.apu_border_we (apu_border_we),
		.apu_covox     (apu_covox),
		.apu_covox_we  (apu_covox_we)
	);

endmodule

// File: verilog/apu_port_out.sv
`timescale 1ns/1ps

module apu_port_out
(
	input  logic                          clk,
	input  logic                          rst,
	input  apu_pkg::out_req_t             out_req,
	output logic [apu_pkg::BORDER_W-1:0]  apu_border,
	output logic                          apu_border_we, // one cycle pulse
	output logic [7:0]                    apu_covox,
	output logic                          apu_covox_we   // one cycle pulse
);

	import apu_pkg::*;

	logic border_hit;
	logic covox_hit;

	// route by port number, anything else falls out here
	assign border_hit = out_req.valid && (out_req.port == port_border);
	assign covox_hit = out_req.valid && (out_req.port == port_covox);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			apu_border <= '0;
			apu_border_we <= 1'b0;
			apu_covox <= '0;
			apu_covox_we <= 1'b0;
		end
		else
		begin
			apu_border_we <= border_hit; // strobes drop unless refreshed
			apu_covox_we <= covox_hit;
			if (border_hit)
				apu_border <= out_req.data[BORDER_W-1:0]; // low bits only
			if (covox_hit)
				apu_covox <= out_req.data; // held till next write
		end
	end

endmodule

// File: verilog/apu_core.sv
`timescale 1ns/1ps

module apu_core
(
	input  logic                clk,
	input  logic                rst,
	input  logic                apu_halt,
	input  apu_pkg::opcode_t    opcode_r,  // word at current pc
	output apu_pkg::code_addr_t pc_next,   // fetch address
	output apu_pkg::out_req_t   out_req,
	output logic                apu_rdy
);

	import apu_pkg::*;

	code_addr_t pc;
	opcode_t    opcode;   // effective word
	op_group_e  grp;
	jcond_e     jc;
	logic [3:0] dst;
	logic [3:0] src;
	logic [7:0] imm;

	logic [7:0] gpr [NUM_GPR]; // register file, not reset
	flags_t     flags;

	alu_func_e  alu_func;
	logic [7:0] alu_arg1;
	logic [7:0] alu_res;
	flags_t     alu_flags;

	logic gpr_we;   // result goes to dst
	logic flags_we; // flag register update
	logic jump_ok;  // condition true
	logic is_halt;

	// halt input looks like a fetched halt word
	assign opcode = apu_halt ? HALT_WORD : opcode_r;

	// fields
	assign grp = op_group_e'(opcode[15:12]);
	assign jc = jcond_e'(opcode[11:8]);
	assign dst = opcode[11:8];
	assign src = opcode[3:0];
	assign imm = opcode[7:0];   // also the jr offset
	assign is_halt = (opcode == HALT_WORD);

	// alu function select
	always_comb
	begin
		case (grp)
			op_ld, op_mov:
				alu_func = alu_pass;
			op_and, op_tst:
				alu_func = alu_and;
			op_or:
				alu_func = alu_or;
			op_xor:
				alu_func = alu_xor;
			op_add:
				alu_func = alu_add;
			op_sub, op_cmp:
				alu_func = alu_sub;
			default:
				alu_func = alu_pass;
		endcase
	end

	// only mov takes a register as second operand
	assign alu_arg1 = (grp == op_mov) ? gpr[src] : imm;

	// tst and cmp set flags but keep dst
	assign gpr_we = grp inside {op_ld, op_and, op_or, op_xor, op_add, op_sub, op_mov};
	assign flags_we = grp inside {op_and, op_or, op_xor, op_add, op_sub, op_tst, op_cmp};

	apu_alu alu0
	(
		.func      (alu_func),
		.arg0      (gpr[dst]),
		.arg1      (alu_arg1),
		.res       (alu_res),
		.flags_out (alu_flags)
	);

	// jump condition against current flags
	always_comb
	begin
		case (jc)
			jc_always:
				jump_ok = 1'b1;
			jc_z:
				jump_ok = flags.z;
			jc_c:
				jump_ok = flags.c;
			jc_nz:
				jump_ok = !flags.z;
			jc_gt:
				jump_ok = !flags.c && !flags.z;
			jc_le:
				jump_ok = flags.c || flags.z;
			jc_nc:
				jump_ok = !flags.c;
			jc_n:
				jump_ok = flags.n;
			jc_p:
				jump_ok = !flags.n;
			default:
				jump_ok = 1'b0; // never
		endcase
	end

	// next fetch address
	always_comb
	begin
		if (apu_halt)
			pc_next = '0; // restart point
		else if (is_halt)
			pc_next = pc; // park on halt word
		else if (grp == op_jr && jump_ok)
			pc_next = pc + 8'd1 + imm; // signed offset wraps mod 256
		else
			pc_next = pc + 8'd1;
	end

	// out request straight from decode
	always_comb
	begin
		out_req.valid = (grp == op_out);
		out_req.port = out_port_e'(src); // unknown numbers dropped downstream
		out_req.data = gpr[dst];
	end

	// control state
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= '0;
			flags <= '0;
			apu_rdy <= 1'b0;
		end
		else
		begin
			pc <= pc_next;
			if (flags_we)
				flags <= alu_flags;
			apu_rdy <= is_halt; // one cycle after halt word seen
		end
	end

	// register file write
	always_ff @(posedge clk)
	begin
		if (gpr_we)
			gpr[dst] <= alu_res;
	end

endmodule

// File: verilog/apu_alu.sv
`timescale 1ns/1ps

module apu_alu
(
	input  apu_pkg::alu_func_e func,
	input  logic [7:0]         arg0,  // dst register
	input  logic [7:0]         arg1,  // imm or src register
	output logic [7:0]         res,
	output apu_pkg::flags_t    flags_out
);

	import apu_pkg::*;

	logic [8:0] sum; // bit 8 is carry or borrow

	always_comb
	begin
		case (func)
			alu_pass:
				sum = {1'b0, arg1}; // ld, mov
			alu_and:
				sum = {1'b0, arg0 & arg1}; // logic ops clear carry
			alu_or:
				sum = {1'b0, arg0 | arg1};
			alu_xor:
				sum = {1'b0, arg0 ^ arg1};
			alu_add:
				sum = {1'b0, arg0} + {1'b0, arg1}; // carry out in bit 8
			alu_sub:
				sum = {1'b0, arg0} - {1'b0, arg1}; // wraps to 1 in bit 8 on borrow
			default:
				sum = {1'b0, arg1};
		endcase
	end

	assign res = sum[7:0];

	// flags from the 8-bit result
	always_comb
	begin
		flags_out.z = (res == 8'd0);
		flags_out.c = sum[8];
		flags_out.n = res[7]; // sign bit
	end

endmodule

// File: verilog/apu_code_ram.sv
`timescale 1ns/1ps

module apu_code_ram
(
	input  logic                clk,
	input  logic                code_wen,
	input  logic [8:0]          code_waddr, // byte address
	input  logic [7:0]          code_wdata,
	input  apu_pkg::code_addr_t rd_addr,
	output apu_pkg::opcode_t    rd_data
);

	import apu_pkg::*;

	opcode_t mem [CODE_DEPTH]; // microcode store

	logic [7:0] lo_byte;    // even byte waits here for its pair
	logic       word_we;
	code_addr_t word_addr;
	opcode_t    word_data;

	// odd byte completes the word
	assign word_we = code_wen && code_waddr[0];
	assign word_addr = code_waddr[8:1];
	assign word_data = {code_wdata, lo_byte}; // high byte from host, low from latch

	// low byte latch
	always_ff @(posedge clk)
	begin
		if (code_wen && !code_waddr[0])
			lo_byte <= code_wdata;
	end

	// word write port
	always_ff @(posedge clk)
	begin
		if (word_we)
			mem[word_addr] <= word_data;
	end

	// registered read, one cycle latency
	// a write shows up on the read after it
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: verilog/apu_pkg.sv
package apu_pkg;

	localparam int CODE_DEPTH = 256; // code words
	localparam int NUM_GPR = 16;     // general registers
	localparam int BORDER_W = 6;     // border port bits

	// code address, doubles as pc
	typedef logic [$clog2(CODE_DEPTH)-1:0] code_addr_t;

	typedef logic [15:0] opcode_t;

	// all ones stops the program
	localparam opcode_t HALT_WORD = 16'hffff;

	// opcode bits 15..12, groups 11..14 fall through as nop
	typedef enum logic [3:0] {
		op_ld   = 4'd0,
		op_and  = 4'd1,
		op_or   = 4'd2,
		op_xor  = 4'd3,
		op_add  = 4'd4,
		op_tst  = 4'd5,  // and, no writeback
		op_cmp  = 4'd6,  // sub, no writeback
		op_sub  = 4'd7,
		op_mov  = 4'd8,  // dst <= src
		op_jr   = 4'd9,
		op_out  = 4'd10, // port[3:0] <= dst reg
		op_misc = 4'd15  // halt or nop
	} op_group_e;

	typedef enum logic [2:0] {
		alu_pass,
		alu_and,
		alu_or,
		alu_xor,
		alu_add,
		alu_sub
	} alu_func_e;

	// jr condition in bits 11..8
	typedef enum logic [3:0] {
		jc_always = 4'd0,
		jc_z      = 4'd1,
		jc_c      = 4'd2,
		jc_nz     = 4'd3,
		jc_gt     = 4'd4, // !c && !z
		jc_le     = 4'd5, // c || z
		jc_nc     = 4'd6,
		jc_n      = 4'd7,
		jc_p      = 4'd8
	} jcond_e;

	// 4-bit wide so that unused port numbers pass through
	typedef enum logic [3:0] {
		port_border = 4'd0,
		port_covox  = 4'd1
	} out_port_e;

	typedef struct packed {
		logic z;
		logic c;
		logic n;
	} flags_t;

	typedef struct packed {
		logic       valid;
		out_port_e  port;
		logic [7:0] data;
	} out_req_t;

endpackage
